//--- src/vision_pkg.sv
// shared definitions for the color vision pipeline
// frame geometry and bank size
// ycbcr to rgb coefficients and offsets
// hue sector bases, hue class centers, black and chroma thresholds
// vector types for samples, products, addresses, class flags and words
// byte phase enum for the 4:2:2 sequencer
package vision_pkg;

	//----------------------------------------------------------------------
	// frame geometry
	//----------------------------------------------------------------------
	localparam int FRAME_W     = 180;                // 720 / 4
	localparam int FRAME_H     = 120;                // 240 field lines / 2
	localparam int FRAME_WORDS = FRAME_W * FRAME_H;  // words per bank

	localparam int SAMPLE_MAX  = 255;                // full scale 8-bit

	//----------------------------------------------------------------------
	// conversion coefficients, x256
	//----------------------------------------------------------------------
	localparam int K_Y  = 298;    // 1.164
	localparam int K_RV = 408;    // 1.596
	localparam int K_GV = 208;    // 0.813
	localparam int K_GU = 100;    // 0.392
	localparam int K_BU = 516;    // 2.017

	localparam int Y_OFFSET = 64;     // 16 at 10-bit scale
	localparam int C_OFFSET = 512;    // 128 at 10-bit scale

	//----------------------------------------------------------------------
	// hue scale, 240 steps per turn
	//----------------------------------------------------------------------
	localparam int HUE_SECTOR = 40;    // one sixth of the circle
	localparam int HUE_G_BASE = 80;
	localparam int HUE_B_BASE = 160;
	localparam int HUE_FULL   = 240;
	localparam int HUE_TOL    = 10;    // half width of each class band

	// class centers
	localparam int HUE_RED    = 230;
	localparam int HUE_ORANGE = 15;
	localparam int HUE_YELLOW = 40;
	localparam int HUE_GREEN  = 90;
	localparam int HUE_BLUE   = 144;

	localparam int V_BLACK  = 96;    // below this is black
	localparam int S_CHROMA = 96;    // above this counts as colored

	//----------------------------------------------------------------------
	// types
	//----------------------------------------------------------------------
	typedef logic [7:0]         sample_t;     // y, cb, cr, r, g, b, h, s, v
	typedef logic signed [20:0] mult_t;       // fixed point product
	typedef logic [14:0]        pix_addr_t;   // word address in one bank
	typedef logic [5:0]         class_t;      // r o y g b black, msb first
	typedef logic [15:0]        pix_word_t;   // stored combination word

	// byte position inside a cb y0 cr y1 quad
	typedef enum logic [1:0] {
		PH_CB,
		PH_Y0,
		PH_CR,
		PH_Y1
	} byte_phase_t;

endpackage

//--- src/video_capture.sv
// 4:2:2 byte sequencer with odd field gating
// 4:1 horizontal and 2:1 vertical decimation
// pixel strobe with held y, cb, cr and field start / end pulses
`timescale 1ns/10ps

module video_capture (
	input  logic                clk_llc,
	input  logic                resetx,
	input  logic                vref,
	input  logic                href,
	input  logic                odd,
	input  vision_pkg::sample_t vpo,
	output logic                cap_valid,
	output logic                field_start,
	output logic                field_end,
	output vision_pkg::sample_t y,
	output vision_pkg::sample_t cb,
	output vision_pkg::sample_t cr
);
	import vision_pkg::*;

	logic        field_act;       // odd field inside vref
	logic        field_act_q;
	logic        href_q;
	logic        href_rise;
	byte_phase_t phase;           // phase of the next byte
	byte_phase_t cur_phase;
	byte_phase_t nxt_phase;
	logic        quad_even;       // next quad is an even one
	logic        cur_quad_even;
	logic        line_par;        // set after a kept line
	logic        line_keep;       // current line is kept
	logic        cur_line_keep;
	logic        take;            // byte belongs to a kept pixel

	assign field_act     = odd & vref;
	assign href_rise     = href & ~href_q;

	// line start restarts the quad sequence
	assign cur_phase     = href_rise ? PH_CB : phase;
	assign cur_quad_even = href_rise ? 1'b1 : quad_even;
	assign cur_line_keep = href_rise ? ~line_par : line_keep;

	assign take = field_act & href & cur_line_keep & cur_quad_even;

	always_comb
	begin
		case (cur_phase)
			PH_CB:   nxt_phase = PH_Y0;
			PH_Y0:   nxt_phase = PH_CR;
			PH_CR:   nxt_phase = PH_Y1;
			default: nxt_phase = PH_CB;
		endcase
	end

	//----------------------------------------------------------------------
	// sequencer and field edges
	//----------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			field_act_q <= 1'b0;
			href_q      <= 1'b0;
			field_start <= 1'b0;
			field_end   <= 1'b0;
			cap_valid   <= 1'b0;
			phase       <= PH_CB;
			quad_even   <= 1'b1;
			line_par    <= 1'b0;
			line_keep   <= 1'b0;
		end
		else
		begin
			field_act_q <= field_act;
			href_q      <= href;
			field_start <= field_act & ~field_act_q;    // rising edge
			field_end   <= ~field_act & field_act_q;    // falling edge
			cap_valid   <= take & (cur_phase == PH_CR);  // cr completes the pixel
			if (href)
			begin
				phase     <= nxt_phase;
				quad_even <= (cur_phase == PH_Y1) ? ~cur_quad_even : cur_quad_even;
				line_keep <= cur_line_keep;
			end
			if (!field_act)
				line_par <= 1'b0;    // first line of next field kept
			else if (href_rise)
				line_par <= ~line_par;
		end
	end

	// byte latches, held until the next kept quad
	always_ff @(posedge clk_llc)
	begin
		if (take)
		begin
			case (cur_phase)
				PH_CB:   cb <= vpo;
				PH_Y0:   y  <= vpo;
				PH_CR:   cr <= vpo;
				default: ;    // y1 dropped
			endcase
		end
	end

endmodule

//--- src/ycbcr_to_rgb.sv
// two stage fixed point ycbcr to rgb888
// stage 1 offset removal and coefficient products
// stage 2 sums with clamp to 0..255
`timescale 1ns/10ps

module ycbcr_to_rgb (
	input  logic                clk_llc,
	input  logic                resetx,
	input  logic                in_valid,
	input  vision_pkg::sample_t y,
	input  vision_pkg::sample_t cb,
	input  vision_pkg::sample_t cr,
	output logic                rgb_valid,
	output vision_pkg::sample_t r,
	output vision_pkg::sample_t g,
	output vision_pkg::sample_t b
);
	import vision_pkg::*;

	logic signed [10:0] y_s;    // 4y - 64
	logic signed [10:0] cb_s;   // 4cb - 512
	logic signed [10:0] cr_s;   // 4cr - 512
	logic               s1_valid;
	mult_t              x;      // luma term
	mult_t              a;      // red from cr
	mult_t              b1;     // green from cr
	mult_t              b2;     // green from cb
	mult_t              c;      // blue from cb

	// negative -> 0, bits 19:18 -> saturate, else 17:10
	function automatic sample_t clamp8(mult_t v);
		if (v[20])
			return '0;
		else if (v[19] | v[18])
			return sample_t'(SAMPLE_MAX);
		else
			return v[17:10];
	endfunction

	assign y_s  = 11'($signed({3'b000, y, 2'b00}) - Y_OFFSET);
	assign cb_s = 11'($signed({3'b000, cb, 2'b00}) - C_OFFSET);
	assign cr_s = 11'($signed({3'b000, cr, 2'b00}) - C_OFFSET);

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid  <= 1'b0;
			rgb_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= in_valid;
			rgb_valid <= s1_valid;
		end
	end

	//----------------------------------------------------------------------
	// stage 1 products
	//----------------------------------------------------------------------
	always_ff @(posedge clk_llc)
	begin
		x  <= mult_t'(K_Y * y_s);
		a  <= mult_t'(K_RV * cr_s);
		b1 <= mult_t'(K_GV * cr_s);
		b2 <= mult_t'(K_GU * cb_s);
		c  <= mult_t'(K_BU * cb_s);
	end

	// stage 2 sums and clamp
	always_ff @(posedge clk_llc)
	begin
		r <= clamp8(x + a);
		g <= clamp8(x - b1 - b2);
		b <= clamp8(x + c);
	end

endmodule

//--- src/rgb_to_hsv.sv
// three stage rgb888 to hsv, hue on a 240 step circle
// stage 1 max, min and dominant component
// stage 2 delta and signed hue difference
// stage 3 v, s and h
`timescale 1ns/10ps

module rgb_to_hsv (
	input  logic                clk_llc,
	input  logic                resetx,
	input  logic                rgb_valid,
	input  vision_pkg::sample_t r,
	input  vision_pkg::sample_t g,
	input  vision_pkg::sample_t b,
	output logic                hsv_valid,
	output vision_pkg::sample_t h,
	output vision_pkg::sample_t s,
	output vision_pkg::sample_t v
);
	import vision_pkg::*;

	logic              is_r;       // red largest, wins ties
	logic              is_g;       // green largest, wins over blue
	sample_t           mx;
	sample_t           mn;
	logic              s1_valid;
	logic              s1_max_r;
	logic              s1_max_g;
	sample_t           s1_max;
	sample_t           s1_min;
	sample_t           s1_r;
	sample_t           s1_g;
	sample_t           s1_b;
	logic              s2_valid;
	logic              s2_max_r;
	logic              s2_max_g;
	sample_t           s2_max;
	sample_t           s2_delta;
	logic signed [8:0] s2_diff;    // -255..255
	int                q;          // 40 * diff / delta
	sample_t           h_n;
	sample_t           s_n;

	always_comb
	begin
		is_r = (r >= g) && (r >= b);
		is_g = !is_r && (g >= b);
		if (is_r)
			mx = r;
		else if (is_g)
			mx = g;
		else
			mx = b;
		mn = r;
		if (g < mn)
			mn = g;
		if (b < mn)
			mn = b;
	end

	//----------------------------------------------------------------------
	// stage 3 arithmetic, division truncates toward zero
	//----------------------------------------------------------------------
	always_comb
	begin
		q = 0;
		if (s2_delta != '0)
			q = (HUE_SECTOR * int'(s2_diff)) / int'(s2_delta);
		if (s2_delta == '0)
			h_n = '0;                                    // gray, no hue
		else if (s2_max_r)
			h_n = sample_t'((q + HUE_FULL) % HUE_FULL);  // wrap around red
		else if (s2_max_g)
			h_n = sample_t'(q + HUE_G_BASE);
		else
			h_n = sample_t'(q + HUE_B_BASE);
		s_n = (s2_max == '0) ? '0 : sample_t'((int'(s2_delta) * SAMPLE_MAX) / int'(s2_max));
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			hsv_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= rgb_valid;
			s2_valid  <= s1_valid;
			hsv_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk_llc)
	begin
		// stage 1
		s1_max_r <= is_r;
		s1_max_g <= is_g;
		s1_max   <= mx;
		s1_min   <= mn;
		s1_r     <= r;
		s1_g     <= g;
		s1_b     <= b;
		// stage 2
		s2_max_r <= s1_max_r;
		s2_max_g <= s1_max_g;
		s2_max   <= s1_max;
		s2_delta <= s1_max - s1_min;
		if (s1_max_r)
			s2_diff <= $signed({1'b0, s1_g}) - $signed({1'b0, s1_b});
		else if (s1_max_g)
			s2_diff <= $signed({1'b0, s1_b}) - $signed({1'b0, s1_r});
		else
			s2_diff <= $signed({1'b0, s1_r}) - $signed({1'b0, s1_g});
		// stage 3
		v <= s2_max;
		s <= s_n;
		h <= h_n;
	end

endmodule

//--- src/color_classifier.sv
// hsv thresholding into black and five hue classes
// packing of the class flags into the 16-bit combination word
`timescale 1ns/10ps

module color_classifier (
	input  logic                  clk_llc,
	input  logic                  resetx,
	input  logic                  hsv_valid,
	input  vision_pkg::sample_t   h,
	input  vision_pkg::sample_t   s,
	input  vision_pkg::sample_t   v,
	output logic                  word_valid,
	output vision_pkg::pix_word_t word
);
	import vision_pkg::*;

	logic   black;
	logic   chroma;      // saturated and not black
	logic   cls_valid;
	class_t cls;         // r o y g b black
	logic   f_r;
	logic   f_o;
	logic   f_y;
	logic   f_g;
	logic   f_b;
	logic   f_k;

	// open band around a hue center
	function automatic logic in_band(sample_t hue, int center);
		return (int'(hue) > center - HUE_TOL) && (int'(hue) < center + HUE_TOL);
	endfunction

	assign black  = v < V_BLACK;
	assign chroma = !black && (s > S_CHROMA);

	assign {f_r, f_o, f_y, f_g, f_b, f_k} = cls;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			cls_valid  <= 1'b0;
			word_valid <= 1'b0;
		end
		else
		begin
			cls_valid  <= hsv_valid;
			word_valid <= cls_valid;
		end
	end

	always_ff @(posedge clk_llc)
	begin
		cls <= {chroma & in_band(h, HUE_RED),
			chroma & in_band(h, HUE_ORANGE),
			chroma & in_band(h, HUE_YELLOW),
			chroma & in_band(h, HUE_GREEN),
			chroma & in_band(h, HUE_BLUE),
			black};
		// combination word, msb first
		word <= {f_r | f_o | f_y, f_r | f_o | f_y | f_k, f_r, f_o, f_y,
			f_g | f_y, f_g | f_y | f_o | f_k, f_g | f_y | f_o, f_g, f_g, f_g,
			f_b, f_b | f_k, f_b, f_b, f_k};
	end

endmodule

//--- src/frame_buffer.sv
// two bank word store for decimated fields
// write address counter, bank toggle and completed bank tracking
// two cycle bank interrupts and registered host read port
`timescale 1ns/10ps

module frame_buffer (
	input  logic                  clk_llc,
	input  logic                  resetx,
	input  logic                  word_valid,
	input  logic                  field_start,
	input  logic                  field_end,
	input  logic                  host_csx,
	input  logic                  host_rdx,
	input  vision_pkg::pix_word_t word,
	input  vision_pkg::pix_addr_t host_adr,
	output vision_pkg::pix_word_t host_data,
	output logic                  irq_bank0,
	output logic                  irq_bank1
);
	import vision_pkg::*;

	pix_word_t mem [0:1][0:FRAME_WORDS-1];
	pix_addr_t wr_addr;
	logic      wr_bank;     // bank being filled
	logic      rd_bank;     // last completed bank
	logic      rd_ready;    // a bank has been completed
	logic      irq_hold;    // second interrupt cycle
	logic      wr_en;
	logic      rd_en;

	assign wr_en = word_valid && (wr_addr < FRAME_WORDS);    // overflow dropped
	assign rd_en = !host_csx && !host_rdx;

	always_ff @(posedge clk_llc)
	begin
		if (wr_en)
			mem[wr_bank][wr_addr] <= word;
	end

	//----------------------------------------------------------------------
	// write side and interrupts
	//----------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			wr_addr   <= '0;
			wr_bank   <= 1'b0;
			rd_bank   <= 1'b0;
			rd_ready  <= 1'b0;
			irq_hold  <= 1'b0;
			irq_bank0 <= 1'b0;
			irq_bank1 <= 1'b0;
		end
		else
		begin
			if (field_start)
				wr_addr <= '0;
			else if (wr_en)
				wr_addr <= wr_addr + 1'b1;
			if (field_end)
			begin
				wr_bank   <= ~wr_bank;
				rd_bank   <= wr_bank;     // completed bank to host
				rd_ready  <= 1'b1;
				irq_bank0 <= ~wr_bank;
				irq_bank1 <= wr_bank;
				irq_hold  <= 1'b1;
			end
			else if (irq_hold)
				irq_hold <= 1'b0;         // keep irq one more cycle
			else
			begin
				irq_bank0 <= 1'b0;
				irq_bank1 <= 1'b0;
			end
		end
	end

	// host read, one cycle after address
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			host_data <= '0;
		else if (rd_en)
		begin
			if (rd_ready && (host_adr < FRAME_WORDS))
				host_data <= mem[rd_bank][host_adr];
			else
				host_data <= '0;          // nothing completed or out of frame
		end
	end

endmodule

//--- src/color_vision_top.sv
// top level of the color vision pipeline
// capture, ycbcr to rgb, rgb to hsv, classifier and frame buffer
`timescale 1ns/10ps

module color_vision_top (
	input  logic                  clk_llc,
	input  logic                  resetx,
	input  logic                  vref,
	input  logic                  href,
	input  logic                  odd,
	input  vision_pkg::sample_t   vpo,
	input  logic                  host_csx,
	input  logic                  host_rdx,
	input  vision_pkg::pix_addr_t host_adr,
	output vision_pkg::pix_word_t host_data,
	output logic                  irq_bank0,
	output logic                  irq_bank1
);
	import vision_pkg::*;

	logic      cap_valid;
	logic      field_start;
	logic      field_end;
	sample_t   cap_y;
	sample_t   cap_cb;
	sample_t   cap_cr;
	logic      rgb_valid;
	sample_t   r;
	sample_t   g;
	sample_t   b;
	logic      hsv_valid;
	sample_t   h;
	sample_t   s;
	sample_t   v;
	logic      word_valid;
	pix_word_t word;

	//----------------------------------------------------------------------
	// pixel path, 7 cycles cap_valid to word_valid
	//----------------------------------------------------------------------
	video_capture u_capture (.clk_llc(clk_llc), .resetx(resetx), .vref(vref),
		.href(href), .odd(odd), .vpo(vpo), .cap_valid(cap_valid),
		.field_start(field_start), .field_end(field_end),
		.y(cap_y), .cb(cap_cb), .cr(cap_cr));

	ycbcr_to_rgb u_ycbcr (.clk_llc(clk_llc), .resetx(resetx), .in_valid(cap_valid),
		.y(cap_y), .cb(cap_cb), .cr(cap_cr), .rgb_valid(rgb_valid),
		.r(r), .g(g), .b(b));

	rgb_to_hsv u_hsv (.clk_llc(clk_llc), .resetx(resetx), .rgb_valid(rgb_valid),
		.r(r), .g(g), .b(b), .hsv_valid(hsv_valid), .h(h), .s(s), .v(v));

	color_classifier u_class (.clk_llc(clk_llc), .resetx(resetx),
		.hsv_valid(hsv_valid), .h(h), .s(s), .v(v),
		.word_valid(word_valid), .word(word));

	// bank store and host side
	frame_buffer u_fbuf (.clk_llc(clk_llc), .resetx(resetx),
		.word_valid(word_valid), .field_start(field_start), .field_end(field_end),
		.host_csx(host_csx), .host_rdx(host_rdx), .word(word), .host_adr(host_adr),
		.host_data(host_data), .irq_bank0(irq_bank0), .irq_bank1(irq_bank1));

endmodule

//--- verif/color_vision_props.sv
// concurrent checks on the color vision top level
// interrupt pulse width, mutual exclusion and cause
// host read port hold when not selected
`timescale 1ns/10ps

module color_vision_props (
	input  logic                  clk_llc,
	input  logic                  resetx,
	input  logic                  field_end,
	input  logic                  irq_bank0,
	input  logic                  irq_bank1,
	input  logic                  host_csx,
	input  logic                  host_rdx,
	input  vision_pkg::pix_word_t host_data
);
	import vision_pkg::*;

	int fail_count = 0;    // assertion failures so far

	//----------------------------------------------------------------------
	// interrupts
	//----------------------------------------------------------------------
	irq0_width: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq_bank0) |=> irq_bank0 ##1 !irq_bank0)
		else
		begin
			$error("irq_bank0 pulse is not two cycles long");
			fail_count++;
		end

	irq1_width: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq_bank1) |=> irq_bank1 ##1 !irq_bank1)
		else
		begin
			$error("irq_bank1 pulse is not two cycles long");
			fail_count++;
		end

	irq_excl: assert property (@(posedge clk_llc) disable iff (!resetx)
		!(irq_bank0 && irq_bank1))
		else
		begin
			$error("both bank interrupts high together");
			fail_count++;
		end

	// only field_end may start a pulse
	irq0_cause: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq_bank0) |-> $past(field_end))
		else
		begin
			$error("irq_bank0 rose without a field end");
			fail_count++;
		end

	irq1_cause: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq_bank1) |-> $past(field_end))
		else
		begin
			$error("irq_bank1 rose without a field end");
			fail_count++;
		end

	// read port idle keeps its last word
	rd_hold: assert property (@(posedge clk_llc) disable iff (!resetx)
		(host_csx || host_rdx) |=> $stable(host_data))
		else
		begin
			$error("host_data changed while the read port was idle");
			fail_count++;
		end

endmodule

//--- verif/tb_color_vision.sv
// testbench for the color vision top level
// odd, even and directed test fields with 4:2:2 byte streams
// reference model of capture, conversion and classification
// host readback against a per bank scoreboard, interrupt checks
`timescale 1ns/10ps

module tb_color_vision;
	import vision_pkg::*;

	localparam int PIX_PER_FIELD  = 12;              // 3 kept lines x 4 pixels
	localparam int FIELD_CYCLES   = 5 + 6 * 40 + 13;  // lead in, lines, tail
	localparam int READ_CYCLES    = 3 * PIX_PER_FIELD;
	localparam int STIM_CYCLES    = 6 * FIELD_CYCLES + 10 * READ_CYCLES + 20;
	localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

	logic      clk_llc;
	logic      resetx;
	logic      vref;
	logic      href;
	logic      odd;
	sample_t   vpo;
	logic      host_csx;
	logic      host_rdx;
	pix_addr_t host_adr;
	pix_word_t host_data;
	logic      irq_bank0;
	logic      irq_bank1;

	integer    seed = 32'hf2dc_3755;
	int        cycles = 0;
	int        word_errs = 0;
	int        irq_errs = 0;
	int        misc_errs = 0;
	int        irq_rises = 0;
	logic      irq0_q = 1'b0;
	logic      irq1_q = 1'b0;
	logic      fill_bank = 1'b0;               // bank the next odd field fills
	pix_word_t sb [0:1][0:PIX_PER_FIELD-1];    // expected words per bank

	// saturated test colors red, orange, yellow, green, blue, gray and black
	sample_t dir_y  [0:6] = '{8'd90, 8'd116, 8'd210, 8'd116, 8'd76, 8'd180, 8'd16};
	sample_t dir_cb [0:6] = '{8'd115, 8'd70, 8'd16, 8'd100, 8'd217, 8'd128, 8'd128};
	sample_t dir_cr [0:6] = '{8'd224, 8'd205, 8'd146, 8'd54, 8'd84, 8'd128, 8'd128};
	class_t  dir_cls [0:6] = '{6'b100000, 6'b010000, 6'b001000, 6'b000100,
		6'b000010, 6'b000000, 6'b000001};

	color_vision_top DUT (.clk_llc(clk_llc), .resetx(resetx), .vref(vref), .href(href),
		.odd(odd), .vpo(vpo), .host_csx(host_csx), .host_rdx(host_rdx),
		.host_adr(host_adr), .host_data(host_data), .irq_bank0(irq_bank0),
		.irq_bank1(irq_bank1));

	bind color_vision_top color_vision_props props (.clk_llc(clk_llc), .resetx(resetx),
		.field_end(field_end), .irq_bank0(irq_bank0), .irq_bank1(irq_bank1),
		.host_csx(host_csx), .host_rdx(host_rdx), .host_data(host_data));

	always #5 clk_llc = ~clk_llc;

	//----------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------
	function automatic int to_byte(int v);
		if (v < 0)
			return 0;
		if (v >= (1 << 18))
			return 255;    // bit 19 or 18 set
		return v / 1024;
	endfunction

	function automatic logic hue_near(int hue, int center);
		return (hue > center - HUE_TOL) && (hue < center + HUE_TOL);
	endfunction

	function automatic pix_word_t pack_word(class_t c);
		pix_word_t w;
		logic fr, fo, fy, fg, fb, fk;
		{fr, fo, fy, fg, fb, fk} = c;
		w[15] = fr | fo | fy;
		w[14] = fr | fo | fy | fk;
		w[13:11] = {fr, fo, fy};
		w[10] = fg | fy;
		w[9] = fg | fy | fo | fk;
		w[8] = fg | fy | fo;
		w[7:4] = {fg, fg, fg, fb};
		w[3] = fb | fk;
		w[2:0] = {fb, fb, fk};
		return w;
	endfunction

	function automatic pix_word_t ref_word(sample_t y, sample_t cb, sample_t cr);
		int yi, ui, vi, x, rr, gg, bb, mx, mn, delta, diff, base, hue, sat;
		logic blk, chr;
		class_t cls;
		yi = 4 * int'(y) - Y_OFFSET;
		ui = 4 * int'(cb) - C_OFFSET;
		vi = 4 * int'(cr) - C_OFFSET;
		x  = K_Y * yi;
		rr = to_byte(x + K_RV * vi);
		gg = to_byte(x - K_GV * vi - K_GU * ui);
		bb = to_byte(x + K_BU * ui);
		if (rr >= gg && rr >= bb)
		begin
			mx = rr;
			diff = gg - bb;
			base = HUE_FULL;    // red wins ties
		end
		else if (gg >= bb)
		begin
			mx = gg;
			diff = bb - rr;
			base = HUE_G_BASE;
		end
		else
		begin
			mx = bb;
			diff = rr - gg;
			base = HUE_B_BASE;
		end
		mn = rr;
		if (gg < mn)
			mn = gg;
		if (bb < mn)
			mn = bb;
		delta = mx - mn;
		hue = (delta == 0) ? 0 : HUE_SECTOR * diff / delta + base;
		if (hue >= HUE_FULL)
			hue = hue - HUE_FULL;    // wrap back past red
		sat = (mx == 0) ? 0 : delta * 255 / mx;
		blk = mx < V_BLACK;
		chr = !blk && (sat > S_CHROMA);
		cls = {chr && hue_near(hue, HUE_RED), chr && hue_near(hue, HUE_ORANGE),
			chr && hue_near(hue, HUE_YELLOW), chr && hue_near(hue, HUE_GREEN),
			chr && hue_near(hue, HUE_BLUE), blk};
		return pack_word(cls);
	endfunction

	//----------------------------------------------------------------------
	// compare tasks
	//----------------------------------------------------------------------
	task automatic check_word(pix_addr_t adr, pix_word_t got, pix_word_t exp);
		if (got !== exp)
		begin
			word_errs++;
			$display("FAIL host_data at 0x%04h got 0x%04h exp 0x%04h", adr, got, exp);
		end
	endtask

	task automatic check_irq(string name, logic got, logic exp);
		if (got !== exp)
		begin
			irq_errs++;
			$display("FAIL %s got 0x%0h exp 0x%0h", name, got, exp);
		end
	endtask

	// one 4:2:2 field of 6 lines with 32 bytes each
	task automatic run_field(input logic is_odd, input logic directed);
		int ln, bt, quad, idx;
		logic kept;
		sample_t byte_v, cb_k, y_k;
		@(posedge clk_llc);
		odd  <= is_odd;
		vref <= 1'b1;
		repeat (4) @(posedge clk_llc);
		for (ln = 0; ln < 6; ln++)
		begin
			for (bt = 0; bt < 32; bt++)
			begin
				quad   = bt / 4;
				idx    = (ln / 2) * 4 + quad / 2;
				kept   = (ln % 2 == 0) && (quad % 2 == 0);    // even line, even quad
				byte_v = sample_t'($random(seed));
				if (kept && directed)
				begin
					case (bt % 4)
						0: byte_v = dir_cb[idx % 7];
						1: byte_v = dir_y[idx % 7];
						2: byte_v = dir_cr[idx % 7];
						default: ;
					endcase
				end
				if (kept && bt % 4 == 0)
					cb_k = byte_v;
				if (kept && bt % 4 == 1)
					y_k = byte_v;
				if (kept && bt % 4 == 2 && is_odd)
					sb[fill_bank][idx] = ref_word(y_k, cb_k, byte_v);
				@(posedge clk_llc);
				href <= 1'b1;
				vpo  <= byte_v;
			end
			@(posedge clk_llc);
			href <= 1'b0;
			repeat (7) @(posedge clk_llc);    // line gap
		end
		@(posedge clk_llc);
		vref <= 1'b0;
		repeat (12) @(posedge clk_llc);
		if (is_odd)
			fill_bank = ~fill_bank;
	endtask

	// two cycle interrupt for one bank with the other one quiet
	task automatic expect_irq(input logic bank);
		int waited;
		waited = 0;
		while (!(irq_bank0 || irq_bank1) && waited < 2 * FIELD_CYCLES)
		begin
			@(negedge clk_llc);
			waited++;
		end
		if (!(irq_bank0 || irq_bank1))
		begin
			misc_errs++;
			$display("no interrupt for bank %0d within %0d cycles", bank, waited);
		end
		else
		begin
			repeat (2)
			begin
				check_irq("irq_bank0", irq_bank0, !bank);
				check_irq("irq_bank1", irq_bank1, bank);
				@(negedge clk_llc);
			end
			check_irq("irq_bank0", irq_bank0, 1'b0);
			check_irq("irq_bank1", irq_bank1, 1'b0);
		end
	endtask

	task automatic read_word(input pix_addr_t adr, output pix_word_t data);
		@(posedge clk_llc);
		host_csx <= 1'b0;
		host_rdx <= 1'b0;
		host_adr <= adr;
		@(posedge clk_llc);    // address taken here
		host_csx <= 1'b1;
		host_rdx <= 1'b1;
		@(negedge clk_llc);
		data = host_data;
	endtask

	task automatic read_bank(input logic bank);
		int a;
		pix_word_t data;
		for (a = 0; a < PIX_PER_FIELD; a++)
		begin
			read_word(pix_addr_t'(a), data);
			check_word(pix_addr_t'(a), data, sb[bank][a]);
		end
	endtask

	// interrupt rise counter
	always @(negedge clk_llc)
	begin
		if ((irq_bank0 && !irq0_q) || (irq_bank1 && !irq1_q))
			irq_rises++;
		irq0_q = irq_bank0;
		irq1_q = irq_bank1;
	end

	always @(posedge clk_llc)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("run stopped after %0d cycles without finishing the tests", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// test sequence
	//----------------------------------------------------------------------
	initial
	begin
		pix_word_t data;
		int a;
		int rises;
		clk_llc = 1'b0;
		resetx = 1'b0;
		vref = 1'b0;
		href = 1'b0;
		odd = 1'b0;
		vpo = '0;
		host_csx = 1'b1;
		host_rdx = 1'b1;
		host_adr = '0;
		repeat (3) @(posedge clk_llc);
		resetx <= 1'b1;
		@(negedge clk_llc);
		check_irq("irq_bank0", irq_bank0, 1'b0);
		check_irq("irq_bank1", irq_bank1, 1'b0);
		read_word('0, data);
		check_word('0, data, '0);    // nothing completed yet
		fork    // random odd field into bank 0
			run_field(1'b1, 1'b0);
			expect_irq(1'b0);
		join
		read_bank(1'b0);
		fork    // directed colors into bank 1
			run_field(1'b1, 1'b1);
			expect_irq(1'b1);
		join
		read_bank(1'b1);
		for (a = 0; a < PIX_PER_FIELD; a++)
		begin
			read_word(pix_addr_t'(a), data);
			check_word(pix_addr_t'(a), data, pack_word(dir_cls[a % 7]));
		end
		rises = irq_rises;
		run_field(1'b0, 1'b0);    // even field ignored
		check_irq("irq rise in even field", logic'(irq_rises != rises), 1'b0);
		read_bank(1'b1);
		fork
			run_field(1'b1, 1'b0);
			expect_irq(1'b0);
		join
		read_bank(1'b0);
		fork
			run_field(1'b1, 1'b0);
			expect_irq(1'b1);
		join
		read_bank(1'b1);
		fork    // host reads bank 1 while bank 0 fills
			run_field(1'b1, 1'b0);
			expect_irq(1'b0);
			repeat (2) read_bank(1'b1);
		join
		read_bank(1'b0);
		$display("errors: word %0d irq %0d other %0d assert %0d", word_errs, irq_errs,
			misc_errs, DUT.props.fail_count);
		if (word_errs + irq_errs + misc_errs + DUT.props.fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- flist.f
src/vision_pkg.sv
src/video_capture.sv
src/ycbcr_to_rgb.sv
src/rgb_to_hsv.sv
src/color_classifier.sv
src/frame_buffer.sv
src/color_vision_top.sv
verif/color_vision_props.sv
verif/tb_color_vision.sv
